/* project.f */
+incdir+design
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_txn_seq.sv
design/eeprom_ctrl_top.sv
dv/tb_clk_gen.sv
dv/eeprom_model.sv
dv/tb_eeprom_ctrl.sv

/* Bender.yml */
package:
  name: eeprom_ctrl

sources:
  - include_dirs:
      - design
    files:
      - design/eeprom_pkg.sv
      - design/i2c_bit_engine.sv
      - design/eeprom_txn_seq.sv
      - design/eeprom_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_clk_gen.sv
      - dv/eeprom_model.sv
      - dv/tb_eeprom_ctrl.sv

/* dv/tb_eeprom_ctrl.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module tb_eeprom_ctrl;

    localparam int N_RAND  = 20;
    localparam int N_TXN   = 2 + (2 * N_RAND + 4) + 2 + 2;
    localparam int TXN_CYC = 45 * 4 * `EE_SCL_QTR; // a read plus slack
    localparam int WDOG_NS = 2 * N_TXN * TXN_CYC * 40 + 20000;

    logic                 CLK;
    logic                 RESET;
    logic                 req_valid;
    logic                 req_write;
    eeprom_pkg::ee_addr_t req_addr;
    eeprom_pkg::ee_data_t req_wdata;
    logic                 rsp_ready;
    logic                 req_ready;
    logic                 rsp_valid;
    eeprom_pkg::ee_data_t rsp_rdata;
    logic                 rsp_err;
    logic                 force_nack;
    wire                  scl;
    wire                  sda;

    eeprom_pkg::ee_data_t ref_mem [0:2047];
    logic                 written [0:2047];
    eeprom_pkg::ee_addr_t addr_list [0:N_RAND-1];
    logic [31:0]          lfsr_state;
    int                   errors;
    int                   checks;

    pullup (scl);
    pullup (sda);

    tb_clk_gen u_tb_clk_gen (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl_top u_eeprom_ctrl_top
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_ready (rsp_ready),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_err   (rsp_err),
        .scl       (scl),
        .sda       (sda)
    );

    eeprom_model u_eeprom_model (.scl(scl), .sda(sda), .force_nack(force_nack));

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic report_err(input string msg);
        errors++;
        $display("ERR @%0t: %s", $time, msg);
    endtask

    // one request, response held for hold cycles before it is taken
    task automatic run_txn(input logic wr, input eeprom_pkg::ee_addr_t addr,
                           input eeprom_pkg::ee_data_t wdata, input int hold,
                           output eeprom_pkg::ee_data_t rdata, output logic err);
        @(posedge CLK);
        req_valid <= 1'b1;
        req_write <= wr;
        req_addr  <= addr;
        req_wdata <= wdata;
        do
            @(negedge CLK);
        while (!req_ready);
        @(posedge CLK); // request transfers
        req_valid <= 1'b0;
        do
            @(negedge CLK);
        while (!rsp_valid);
        rdata = rsp_rdata;
        err   = rsp_err;
        repeat (hold)
        begin
            @(negedge CLK);
            checks++;
            if (!rsp_valid || rsp_rdata !== rdata || rsp_err !== err || req_ready)
                report_err($sformatf("response at %h changed under back-pressure", addr));
        end
        @(posedge CLK);
        rsp_ready <= 1'b1;
        @(posedge CLK); // response transfers
        rsp_ready <= 1'b0;
        @(negedge CLK);
        checks++;
        if (rsp_valid || !req_ready)
            report_err("channels not back to idle after the response");
    endtask

    task automatic write_byte(input eeprom_pkg::ee_addr_t addr, input eeprom_pkg::ee_data_t data,
                              input logic exp_err, input int hold);
        eeprom_pkg::ee_data_t rdata;
        logic                 err;
        run_txn(1'b1, addr, data, hold, rdata, err);
        checks++;
        if (err !== exp_err)
            report_err($sformatf("write %h: rsp_err %b, expected %b", addr, err, exp_err));
        if (rdata !== 8'h00)
            report_err($sformatf("write %h: rsp_rdata %h, expected 00", addr, rdata));
        if (!exp_err)
        begin
            ref_mem[addr] = data;
            written[addr] = 1'b1;
        end
    endtask

    task automatic read_expect(input eeprom_pkg::ee_addr_t addr, input eeprom_pkg::ee_data_t exp,
                               input int hold);
        eeprom_pkg::ee_data_t rdata;
        logic                 err;
        run_txn(1'b0, addr, 8'h00, hold, rdata, err);
        checks++;
        if (err !== 1'b0)
            report_err($sformatf("read %h: rsp_err set", addr));
        if (rdata !== exp)
            report_err($sformatf("read %h: got %h, expected %h", addr, rdata, exp));
    endtask

    task automatic check_reset();
        int n;
        n = 0;
        @(negedge CLK);
        while (RESET !== 1'b0)
            @(negedge CLK);
        checks++;
        if (rsp_valid !== 1'b0 || scl !== 1'b1 || sda !== 1'b1)
            report_err("response or bus not idle after reset");
        while (req_ready !== 1'b1 && n < 2)
        begin
            @(negedge CLK);
            n++;
        end
        if (req_ready !== 1'b1)
            report_err("req_ready not high within two cycles of reset");
    endtask

    task automatic write_read_back();
        write_byte(11'h2A5, 8'h3C, 1'b0, 0);
        read_expect(11'h2A5, 8'h3C, 0);
    endtask

    // block i%8 in turn so every block is hit
    task automatic block_sweep();
        logic [31:0]          r;
        eeprom_pkg::ee_addr_t a;
        int                   n;
        int                   k;
        for (int i = 0; i < N_RAND; i++)
        begin
            r = rand_bits(8);
            a = {i[2:0], r[7:0]};
            r = rand_bits(8);
            write_byte(a, r[7:0], 1'b0, 0);
            addr_list[i] = a;
        end
        for (int i = 0; i < N_RAND; i++)
            read_expect(addr_list[i], ref_mem[addr_list[i]], 0);
        n = 0;
        k = 0;
        while (n < 4)
        begin
            // same word as a written byte, in another block
            r = rand_bits(3);
            a = {r[2:0], addr_list[k][7:0]};
            k = (k + 1) % N_RAND;
            if (!written[a])
            begin
                read_expect(a, 8'hFF, 0); // still erased
                n++;
            end
        end
    endtask

    task automatic forced_nack();
        @(posedge CLK);
        force_nack <= 1'b1;
        write_byte(11'h2A5, 8'hC3, 1'b1, 0);
        @(posedge CLK);
        force_nack <= 1'b0;
        read_expect(11'h2A5, ref_mem[11'h2A5], 0);
    endtask

    task automatic response_backpressure();
        logic [31:0] r;
        r = rand_bits(4);
        write_byte(11'h7F0, 8'h5A, 1'b0, 3 + r[3:0]);
        r = rand_bits(4);
        read_expect(11'h7F0, 8'h5A, 3 + r[3:0]);
    endtask

    initial
    begin
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        rsp_ready  = 1'b0;
        force_nack = 1'b0;
        lfsr_state = 32'h16bf;
        errors     = 0;
        checks     = 0;
        for (int i = 0; i < 2048; i++)
        begin
            ref_mem[i] = 8'hFF;
            written[i] = 1'b0;
        end
        check_reset();
        write_read_back();
        block_sweep();
        forced_nack();
        response_backpressure();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial
    begin
        #(WDOG_NS);
        $display("timeout: the tests did not complete within %0d ns", WDOG_NS);
        $display("checks: %0d  errors: %0d", checks, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* dv/eeprom_model.sv */
`timescale 1ns/1ps

module eeprom_model
(
    input  wire  scl,
    inout  wire  sda,
    input  logic force_nack
);

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_READ
    } mdl_state_e;

    logic [7:0]  mem [0:2047];
    mdl_state_e  st;
    logic [7:0]  sh;
    logic [3:0]  bitn;
    logic [10:0] ptr;
    logic        ack_slot;  // model owns sda for the ack bit
    logic        sda_low;
    logic        scl_q;
    logic        sda_q;
    logic        ack;

    assign sda = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hFF; // erased array
        st       = M_IDLE;
        sh       = 8'h00;
        bitn     = 4'd0;
        ptr      = '0;
        ack_slot = 1'b0;
        sda_low  = 1'b0;
    end

    always @(scl or sda)
    begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
        begin
            st       = M_CTRL; // start or repeated start
            bitn     = 4'd0;
            ack_slot = 1'b0;
        end
        else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1)
        begin
            st = M_IDLE; // stop
        end
        else if (scl_q === 1'b0 && scl === 1'b1)
        begin
            if (st != M_IDLE && !ack_slot && bitn < 4'd8)
            begin
                if (st != M_READ)
                    sh = {sh[6:0], (sda !== 1'b0)};
                bitn = bitn + 4'd1;
            end
        end
        else if (scl_q === 1'b1 && scl === 1'b0)
        begin
            if (ack_slot)
            begin
                ack_slot = 1'b0;
                sda_low  = 1'b0;
                bitn     = 4'd0;
                if (st == M_READ)
                begin
                    sh      = mem[ptr];
                    sda_low = ~sh[7];
                end
            end
            else if (st == M_READ)
            begin
                if (bitn == 4'd8)
                begin
                    sda_low = 1'b0; // host answers, one byte only
                    st      = M_IDLE;
                end
                else
                    sda_low = ~sh[7 - bitn];
            end
            else if (st != M_IDLE && bitn == 4'd8)
            begin
                ack = !force_nack && (st != M_CTRL || sh[7:4] == 4'b1010);
                if (!ack)
                    st = M_IDLE;
                else if (st == M_CTRL)
                begin
                    ptr[10:8] = sh[3:1]; // block bits
                    st        = sh[0] ? M_READ : M_ADDR;
                end
                else if (st == M_ADDR)
                begin
                    ptr[7:0] = sh;
                    st       = M_DATA;
                end
                else
                begin
                    mem[ptr] = sh;
                    st       = M_IDLE;
                end
                sda_low  = ack;
                ack_slot = ack;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen
(
    output logic CLK,
    output logic RESET
);

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK; // 40 ns period
    end

    initial
    begin
        RESET = 1'b1;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
    end

endmodule

/* design/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  eeprom_pkg::ee_addr_t  req_addr,
    input  eeprom_pkg::ee_data_t  req_wdata,
    input  logic                  rsp_ready,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output eeprom_pkg::ee_data_t  rsp_rdata,
    output logic                  rsp_err,
    output logic                  scl,
    inout  wire                   sda
);

    logic                 cmd_valid;
    logic                 cmd_ready;
    eeprom_pkg::i2c_cmd_e cmd_op;
    eeprom_pkg::ee_data_t cmd_wbyte;
    logic                 cmd_nack_out;
    logic                 done;
    eeprom_pkg::ee_data_t rx_byte;
    logic                 ack_in;
    logic                 sda_drive_low;

    // open drain, the pull-up sits outside
    assign sda = sda_drive_low ? 1'b0 : 1'bz;

    eeprom_txn_seq u_eeprom_txn_seq
    (
        .CLK          (CLK),
        .RESET        (RESET),
        .req_valid    (req_valid),
        .req_write    (req_write),
        .req_addr     (req_addr),
        .req_wdata    (req_wdata),
        .rsp_ready    (rsp_ready),
        .cmd_ready    (cmd_ready),
        .done         (done),
        .rx_byte      (rx_byte),
        .ack_in       (ack_in),
        .req_ready    (req_ready),
        .rsp_valid    (rsp_valid),
        .rsp_rdata    (rsp_rdata),
        .rsp_err      (rsp_err),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_wbyte    (cmd_wbyte),
        .cmd_nack_out (cmd_nack_out)
    );

    i2c_bit_engine u_i2c_bit_engine
    (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_wbyte     (cmd_wbyte),
        .cmd_nack_out  (cmd_nack_out),
        .sda_in        (sda),       // read back from the pin
        .cmd_ready     (cmd_ready),
        .done          (done),
        .rx_byte       (rx_byte),
        .ack_in        (ack_in),
        .scl           (scl),
        .sda_drive_low (sda_drive_low)
    );

endmodule

/* design/eeprom_txn_seq.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module eeprom_txn_seq
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_valid,
    input  logic                  req_write,
    input  eeprom_pkg::ee_addr_t  req_addr,
    input  eeprom_pkg::ee_data_t  req_wdata,
    input  logic                  rsp_ready,
    input  logic                  cmd_ready,
    input  logic                  done,
    input  eeprom_pkg::ee_data_t  rx_byte,
    input  logic                  ack_in,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output eeprom_pkg::ee_data_t  rsp_rdata,
    output logic                  rsp_err,
    output logic                  cmd_valid,
    output eeprom_pkg::i2c_cmd_e  cmd_op,
    output eeprom_pkg::ee_data_t  cmd_wbyte,
    output logic                  cmd_nack_out
);

    typedef enum logic [3:0]
    {
        SQ_IDLE,
        SQ_START,
        SQ_CTRL_W,
        SQ_ADDR,
        SQ_DATA,
        SQ_RESTART,
        SQ_CTRL_R,
        SQ_READ,
        SQ_STOP,
        SQ_RSP
    } seq_state_e;

    seq_state_e           state;
    logic                 wr_q;
    eeprom_pkg::ee_addr_t addr_q;
    eeprom_pkg::ee_data_t wdata_q;

    // command fields follow the state, so they hold until accepted
    always_comb
    begin
        case (state)
            SQ_START, SQ_RESTART: cmd_op = eeprom_pkg::CMD_START;
            SQ_READ:              cmd_op = eeprom_pkg::CMD_READ;
            SQ_STOP:              cmd_op = eeprom_pkg::CMD_STOP;
            default:              cmd_op = eeprom_pkg::CMD_WRITE;
        endcase
    end

    always_comb
    begin
        case (state)
            SQ_CTRL_W: cmd_wbyte = {`EE_DEV_CODE, addr_q[10:8], 1'b0}; // block bits, write
            SQ_ADDR:   cmd_wbyte = addr_q[7:0];
            SQ_DATA:   cmd_wbyte = wdata_q;
            SQ_CTRL_R: cmd_wbyte = {`EE_DEV_CODE, addr_q[10:8], 1'b1};
            default:   cmd_wbyte = 8'h00;
        endcase
    end

    assign cmd_nack_out = (state == SQ_READ); // single byte read ends in nack

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= SQ_IDLE;
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp_err   <= 1'b0;
            cmd_valid <= 1'b0;
        end
        else
        begin
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;

            case (state)
                SQ_IDLE:
                begin
                    if (req_valid && req_ready)
                    begin
                        req_ready <= 1'b0;
                        rsp_err   <= 1'b0;
                        cmd_valid <= 1'b1;
                        state     <= SQ_START;
                    end
                    else
                    begin
                        req_ready <= 1'b1;
                    end
                end
                SQ_START:
                begin
                    if (done)
                    begin
                        cmd_valid <= 1'b1;
                        state     <= SQ_CTRL_W;
                    end
                end
                SQ_CTRL_W, SQ_ADDR, SQ_CTRL_R:
                begin
                    if (done)
                    begin
                        cmd_valid <= 1'b1;
                        if (!ack_in)
                        begin
                            rsp_err <= 1'b1; // no ack, skip to stop
                            state   <= SQ_STOP;
                        end
                        else if (state == SQ_CTRL_W)
                            state <= SQ_ADDR;
                        else if (state == SQ_CTRL_R)
                            state <= SQ_READ;
                        else if (wr_q)
                            state <= SQ_DATA;
                        else
                            state <= SQ_RESTART;
                    end
                end
                SQ_DATA:
                begin
                    if (done)
                    begin
                        cmd_valid <= 1'b1;
                        rsp_err   <= !ack_in;
                        state     <= SQ_STOP;
                    end
                end
                SQ_RESTART:
                begin
                    if (done)
                    begin
                        cmd_valid <= 1'b1;
                        state     <= SQ_CTRL_R;
                    end
                end
                SQ_READ:
                begin
                    if (done)
                    begin
                        cmd_valid <= 1'b1;
                        state     <= SQ_STOP;
                    end
                end
                SQ_STOP:
                begin
                    if (done)
                    begin
                        rsp_valid <= 1'b1;
                        state     <= SQ_RSP;
                    end
                end
                SQ_RSP:
                begin
                    // bus already idle, just wait for the host
                    if (rsp_ready)
                    begin
                        rsp_valid <= 1'b0;
                        req_ready <= 1'b1;
                        state     <= SQ_IDLE;
                    end
                end
                default:
                    state <= SQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            wr_q      <= req_write;
            addr_q    <= req_addr;
            wdata_q   <= req_wdata;
            rsp_rdata <= '0; // writes report zero
        end
        else if (state == SQ_READ && done)
        begin
            rsp_rdata <= rx_byte;
        end
    end

    a_rsp_hold: assert property (@(posedge CLK) disable iff (RESET)
        (rsp_valid && !rsp_ready)
            |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_err)));

endmodule

/* design/i2c_bit_engine.sv */
`timescale 1ns/1ps
`include "eeprom_consts.svh"

module i2c_bit_engine
(
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_valid,
    input  eeprom_pkg::i2c_cmd_e  cmd_op,
    input  eeprom_pkg::ee_data_t  cmd_wbyte,
    input  logic                  cmd_nack_out,
    input  logic                  sda_in,
    output logic                  cmd_ready,
    output logic                  done,
    output eeprom_pkg::ee_data_t  rx_byte,
    output logic                  ack_in,
    output logic                  scl,
    output logic                  sda_drive_low
);

    localparam int QW = $clog2(`EE_SCL_QTR + 1);
    localparam logic [QW-1:0] QTR_LAST = QW'(`EE_SCL_QTR - 1);

    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_START,
        ST_STOP,
        ST_WRITE,
        ST_READ
    } eng_state_e;

    eng_state_e           state;
    logic [QW-1:0]        qcnt;     // cycles within a quarter
    logic [1:0]           phase;    // quarter within the SCL period
    logic [3:0]           bit_cnt;  // 0..7 data, 8 ack slot
    eeprom_pkg::ee_data_t shreg;
    logic                 nack_q;
    logic                 drive_bit;
    logic                 last_period;
    logic                 byte_cmd;
    logic                 sample_now;

    assign cmd_ready = (state == ST_IDLE);
    assign rx_byte   = shreg;

    assign byte_cmd    = (state == ST_WRITE) || (state == ST_READ);
    assign last_period = (state == ST_START) || (state == ST_STOP) || (bit_cnt == 4'd8);
    assign sample_now  = (phase == 2'd2) && (qcnt == QTR_LAST); // late in the high quarter

    // sda level for the low half of the current period
    always_comb
    begin
        case (state)
            ST_STOP:
                drive_bit = 1'b1;
            ST_WRITE:
                drive_bit = (bit_cnt < 4'd8) ? ~shreg[7] : 1'b0;
            ST_READ:
                drive_bit = (bit_cnt == 4'd8) && !nack_q;
            default:
                drive_bit = 1'b0; // start releases sda first
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= ST_IDLE;
            qcnt          <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            done          <= 1'b0;
            ack_in        <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (state == ST_IDLE)
            begin
                if (cmd_valid && cmd_ready)
                begin
                    case (cmd_op)
                        eeprom_pkg::CMD_START: state <= ST_START;
                        eeprom_pkg::CMD_STOP:  state <= ST_STOP;
                        eeprom_pkg::CMD_WRITE: state <= ST_WRITE;
                        default:               state <= ST_READ;
                    endcase
                    qcnt    <= '0;
                    phase   <= 2'd0;
                    bit_cnt <= 4'd0;
                    scl     <= 1'b0; // first period starts low
                    ack_in  <= 1'b0;
                end
            end
            else
            begin
                if (qcnt == QTR_LAST)
                begin
                    qcnt  <= '0;
                    phase <= phase + 2'd1;
                    if (phase == 2'd1)
                    begin
                        scl <= 1'b1;
                    end
                    else if (phase == 2'd3)
                    begin
                        if (last_period)
                        begin
                            state <= ST_IDLE; // scl rests high
                            done  <= 1'b1;
                        end
                        else
                        begin
                            scl     <= 1'b0;
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                end
                else
                begin
                    qcnt <= qcnt + 1'b1;
                end

                if (state == ST_WRITE && sample_now && bit_cnt == 4'd8)
                    ack_in <= ~sda_in; // memory pulls low to ack

                // one cycle after scl falls, so data never moves with the edge
                if (qcnt == '0)
                begin
                    if (phase == 2'd0)
                    begin
                        sda_drive_low <= drive_bit;
                    end
                    else if (phase == 2'd3 && (state == ST_START || state == ST_STOP))
                    begin
                        // sda edge while scl high marks start or stop
                        sda_drive_low <= (state == ST_START);
                    end
                end
            end
        end
    end

    // shift register serves both directions, msb first
    always_ff @(posedge CLK)
    begin
        if (cmd_valid && cmd_ready)
        begin
            shreg  <= cmd_wbyte;
            nack_q <= cmd_nack_out;
        end
        else if (byte_cmd && sample_now && bit_cnt < 4'd8)
        begin
            shreg <= {shreg[6:0], sda_in};
        end
    end

    a_cmd_hold: assert property (@(posedge CLK) disable iff (RESET)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable(cmd_op)));

    // data may only move under a high clock when framing the transfer
    a_sda_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_drive_low))
            |-> ($past(state) inside {ST_START, ST_STOP}));

endmodule

/* design/eeprom_pkg.sv */
package eeprom_pkg;

    // byte address into the 2 KB array
    // bits 10:8 pick the block, bits 7:0 the word
    typedef logic [10:0] ee_addr_t;

    typedef logic [7:0] ee_data_t;

    // bus commands run by the bit engine
    typedef enum logic [1:0]
    {
        CMD_START, // start or repeated start
        CMD_STOP,
        CMD_WRITE, // byte out, then sample ack
        CMD_READ   // byte in, then send ack or nack
    } i2c_cmd_e;

endpackage

/* design/eeprom_consts.svh */
`ifndef EE_CONSTS_SVH
`define EE_CONSTS_SVH

// CLK cycles per quarter of an SCL period
// the default of 4 gives a 16-cycle SCL period
`define EE_SCL_QTR 4

// device type code in the top nibble of the control byte
`define EE_DEV_CODE 4'b1010

`endif
